//--- src/OramTestPkg.sv
// Shared widths and command codes of the ORAM test wrapper
package OramTestPkg;

	// Beat width, same on the frontend and DRAM data buses
	localparam int DataWidth = 64;
	// One DRAM mask bit per byte
	localparam int MaskWidth = DataWidth / 8;

	// Block address on the user port
	localparam int AddrWidth = 16;
	// DRAM address counts beats
	localparam int DramAddrWidth = 24;

	// ----------------------------------------------------------
	// User commands
	// ----------------------------------------------------------
	localparam int CmdWidth = 2;
	localparam logic [CmdWidth-1:0] CmdWrite = 2'd0;
	localparam logic [CmdWidth-1:0] CmdRead = 2'd1;

	// ----------------------------------------------------------
	// DRAM commands, DDR3 controller codes
	// ----------------------------------------------------------
	localparam int DramCmdWidth = 3;
	localparam logic [DramCmdWidth-1:0] DramCmdWrite = 3'd0;
	localparam logic [DramCmdWidth-1:0] DramCmdRead = 3'd1;

endpackage

//--- src/BeatCounter.sv
`timescale 1ns/1ps
// Modulo counter for beats within a block, with last-beat flag
module BeatCounter #(
	parameter int BeatsPerBlock = 4,
	localparam int IndexWidth = (BeatsPerBlock > 1) ? $clog2(BeatsPerBlock) : 1
) (
	input  logic                  Clock,
	input  logic                  arstN,
	input  logic                  BeatStep,
	input  logic                  BeatClear,
	output logic [IndexWidth-1:0] BeatIndex,
	output logic                  LastBeat
);

	assign LastBeat = (BeatIndex == IndexWidth'(BeatsPerBlock - 1));

	// Clear wins over step
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			BeatIndex <= '0;
		end else if (BeatClear) begin
			BeatIndex <= '0;
		end else if (BeatStep) begin
			// Wrap after the last beat
			if (LastBeat)
				BeatIndex <= '0;
			else
				BeatIndex <= BeatIndex + 1'b1;
		end
	end

endmodule

//--- src/BlockBuffer.sv
`timescale 1ns/1ps
// Beat storage for one block plus its latched write mask
module BlockBuffer import OramTestPkg::*; #(
	parameter int BeatsPerBlock = 4,
	localparam int IndexWidth = (BeatsPerBlock > 1) ? $clog2(BeatsPerBlock) : 1
) (
	input  logic                     Clock,
	input  logic                     arstN,
	input  logic                     BufWrite,
	input  logic                     BufFromDram,
	input  logic [IndexWidth-1:0]    BeatIndex,
	input  logic [BeatsPerBlock-1:0] WMask,
	input  logic                     LoadMask,
	input  logic [DataWidth-1:0]     DataIn,
	input  logic [DataWidth-1:0]     DramReadData,
	output logic [DataWidth-1:0]     BeatData,
	output logic [MaskWidth-1:0]     BeatMask
);

	logic [DataWidth-1:0] beats [BeatsPerBlock];
	// One bit per beat, 1 means the beat is written
	logic [BeatsPerBlock-1:0] maskReg;

	// Fill from user or from DRAM, slot given by the beat counter
	always_ff @(posedge Clock) begin
		if (BufWrite)
			beats[BeatIndex] <= BufFromDram ? DramReadData : DataIn;
	end

	// Mask captured when the command is accepted
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN)
			maskReg <= '1;
		else if (LoadMask)
			maskReg <= WMask;
	end

	// Same slot feeds DataOut and DRAM write data
	assign BeatData = beats[BeatIndex];

	// DRAM mask is active high, all ones drops the beat
	assign BeatMask = maskReg[BeatIndex] ? {MaskWidth{1'b0}} : {MaskWidth{1'b1}};

endmodule

//--- src/AccessFsm.sv
`timescale 1ns/1ps
// Sequencer for one block read or write at a time
// Also runs the endless dummy read loop for power tests
module AccessFsm import OramTestPkg::*; #(
	parameter int BeatsPerBlock = 4
) (
	input  logic                     Clock,
	input  logic                     arstN,
	input  logic [CmdWidth-1:0]      Cmd,
	input  logic [AddrWidth-1:0]     PAddr,
	input  logic                     CmdValid,
	output logic                     CmdReady,
	input  logic                     DataInValid,
	output logic                     DataInReady,
	output logic                     DataOutValid,
	input  logic                     DataOutReady,
	output logic [DramAddrWidth-1:0] DramAddress,
	output logic [DramCmdWidth-1:0]  DramCommand,
	output logic                     DramCommandValid,
	input  logic                     DramCommandReady,
	input  logic                     DramReadDataValid,
	output logic                     DramWriteDataValid,
	input  logic                     DramWriteDataReady,
	input  logic                     DummyMode,
	input  logic                     LastBeat,
	output logic                     BeatStep,
	output logic                     BeatClear,
	output logic                     BufWrite,
	output logic                     BufFromDram
);

	typedef enum logic [2:0] {
		Idle,
		FillFromUser,
		IssueDram,
		WriteBeats,
		CollectRead,
		DrainToUser
	} stateT;

	stateT state;
	stateT stateNext;
	logic [AddrWidth-1:0] blockAddr;
	logic isWrite;
	logic cmdFire;
	logic dramCmdFire;

	assign cmdFire = CmdValid && CmdReady;
	assign dramCmdFire = DramCommandValid && DramCommandReady;

	// ----------------------------------------------------------
	// Next state
	// ----------------------------------------------------------
	always_comb begin
		stateNext = state;
		case (state)
			Idle: begin
				// Dummy loop skips the user side entirely
				if (DummyMode)
					stateNext = IssueDram;
				else if (cmdFire)
					stateNext = (Cmd == CmdWrite) ? FillFromUser : IssueDram;
			end
			FillFromUser:
				if (BeatStep && LastBeat)
					stateNext = IssueDram;
			IssueDram:
				if (dramCmdFire)
					stateNext = isWrite ? WriteBeats : CollectRead;
			WriteBeats:
				if (BeatStep && LastBeat)
					stateNext = Idle;
			CollectRead:
				// Dummy reads are dropped once collected
				if (BeatStep && LastBeat)
					stateNext = DummyMode ? Idle : DrainToUser;
			DrainToUser:
				if (BeatStep && LastBeat)
					stateNext = Idle;
			default:
				stateNext = Idle;
		endcase
	end

	// ----------------------------------------------------------
	// State, block address and direction
	// ----------------------------------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= Idle;
			blockAddr <= '0;
			isWrite <= 1'b0;
		end else begin
			state <= stateNext;
			if (state == Idle && DummyMode) begin
				// Own address walk in dummy mode
				blockAddr <= blockAddr + 1'b1;
				isWrite <= 1'b0;
			end else if (cmdFire) begin
				blockAddr <= PAddr;
				isWrite <= (Cmd == CmdWrite);
			end
		end
	end

	// Handshake outputs straight from the state
	assign CmdReady = (state == Idle) && !DummyMode;
	assign DataInReady = (state == FillFromUser);
	assign DataOutValid = (state == DrainToUser);
	assign DramCommandValid = (state == IssueDram);
	assign DramWriteDataValid = (state == WriteBeats);

	// Block base in beats
	assign DramAddress = DramAddrWidth'(blockAddr) * DramAddrWidth'(BeatsPerBlock);
	assign DramCommand = isWrite ? DramCmdWrite : DramCmdRead;

	// One step per beat transfer in the current state
	always_comb begin
		case (state)
			FillFromUser: BeatStep = DataInValid;
			WriteBeats:   BeatStep = DramWriteDataReady;
			CollectRead:  BeatStep = DramReadDataValid;
			DrainToUser:  BeatStep = DataOutReady;
			default:      BeatStep = 1'b0;
		endcase
	end

	// Counter restarts on every state entry
	assign BeatClear = (stateNext != state);

	assign BufFromDram = (state == CollectRead);
	assign BufWrite = ((state == FillFromUser) && DataInValid) ||
		((state == CollectRead) && DramReadDataValid);

endmodule

//--- src/TrafficPatternGen.sv
`timescale 1ns/1ps
// On-chip traffic generator, writes pattern blocks and reads them back
// Mismatching beats are counted, saturating
module TrafficPatternGen import OramTestPkg::*; #(
	parameter int BeatsPerBlock = 4,
	parameter int PatternBlocks = 8,
	localparam int IndexWidth = (BeatsPerBlock > 1) ? $clog2(BeatsPerBlock) : 1,
	localparam int BlockWidth = (PatternBlocks > 1) ? $clog2(PatternBlocks) : 1
) (
	input  logic                 Clock,
	input  logic                 arstN,
	input  logic                 Enable,
	output logic [CmdWidth-1:0]  Cmd,
	output logic [AddrWidth-1:0] PAddr,
	output logic                 CmdValid,
	input  logic                 CmdReady,
	output logic [DataWidth-1:0] DataIn,
	output logic                 DataInValid,
	input  logic                 DataInReady,
	input  logic [DataWidth-1:0] DataOut,
	input  logic                 DataOutValid,
	output logic                 DataOutReady,
	output logic                 PatternDone,
	output logic [7:0]           PatternErrors
);

	typedef enum logic [2:0] {
		TgIdle,
		TgWriteCmd,
		TgWriteData,
		TgReadCmd,
		TgReadData
	} tgStateT;

	tgStateT state;
	logic enableQ;
	logic start;
	logic [IndexWidth-1:0] beatIdx;
	logic [BlockWidth-1:0] blockIdx;
	logic beatLast;
	logic blockLast;
	logic beatStep;
	logic blockStep;
	logic [15:0] patValue;
	logic [DataWidth-1:0] expected;

	// Run begins on the rising edge of the mode level
	assign start = Enable && !enableQ;

	// Beat j of block b carries b*256+j, repeated over the word
	assign patValue = (16'(blockIdx) << 8) | 16'(beatIdx);
	assign expected = {(DataWidth / 16){patValue}};

	assign beatStep = ((state == TgWriteData) && DataInReady) ||
		((state == TgReadData) && DataOutValid);
	assign blockStep = beatStep && beatLast;

	BeatCounter #(.BeatsPerBlock(BeatsPerBlock)) i_beatCounter (
		.Clock(Clock), .arstN(arstN),
		.BeatStep(beatStep), .BeatClear(start),
		.BeatIndex(beatIdx), .LastBeat(beatLast)
	);

	// Block counter, wraps back to 0 between write and read passes
	BeatCounter #(.BeatsPerBlock(PatternBlocks)) i_blockCounter (
		.Clock(Clock), .arstN(arstN),
		.BeatStep(blockStep), .BeatClear(start),
		.BeatIndex(blockIdx), .LastBeat(blockLast)
	);

	// ----------------------------------------------------------
	// Sequence and checking
	// ----------------------------------------------------------
	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= TgIdle;
			enableQ <= 1'b0;
			PatternDone <= 1'b0;
			PatternErrors <= '0;
		end else begin
			enableQ <= Enable;
			if (start) begin
				state <= TgWriteCmd;
				PatternDone <= 1'b0;
				PatternErrors <= '0;
			end else begin
				case (state)
					TgWriteCmd:
						if (CmdReady)
							state <= TgWriteData;
					TgWriteData:
						if (blockStep)
							state <= blockLast ? TgReadCmd : TgWriteCmd;
					TgReadCmd:
						if (CmdReady)
							state <= TgReadData;
					TgReadData: begin
						// Compare each returned beat, stop counting at 255
						if (DataOutValid && DataOut != expected && PatternErrors != 8'hFF)
							PatternErrors <= PatternErrors + 1'b1;
						if (blockStep && blockLast) begin
							state <= TgIdle;
							PatternDone <= 1'b1;
						end else if (blockStep) begin
							state <= TgReadCmd;
						end
					end
					default:
						state <= TgIdle;
				endcase
			end
		end
	end

	assign Cmd = (state == TgWriteCmd) ? CmdWrite : CmdRead;
	assign PAddr = AddrWidth'(blockIdx);
	assign CmdValid = (state == TgWriteCmd) || (state == TgReadCmd);
	assign DataIn = expected;
	assign DataInValid = (state == TgWriteData);
	assign DataOutReady = (state == TgReadData);

endmodule

//--- src/DummyReadResponder.sv
`timescale 1ns/1ps
// Local DRAM stand-in for power runs that answers reads with LFSR data
module DummyReadResponder import OramTestPkg::*; #(
	parameter int BeatsPerBlock = 4,
	parameter int DummyLatency = 3,
	localparam int IndexWidth = (BeatsPerBlock > 1) ? $clog2(BeatsPerBlock) : 1,
	localparam int TimerWidth = $clog2(DummyLatency) + 1
) (
	input  logic                 Clock,
	input  logic                 arstN,
	input  logic                 CommandValid,
	output logic                 CommandReady,
	output logic [DataWidth-1:0] ReadData,
	output logic                 ReadDataValid
);

	logic waiting;
	logic sending;
	logic accept;
	logic lastBeat;
	logic [TimerWidth-1:0] timer;
	logic [DataWidth-1:0] lfsr;

	// One command at a time
	assign CommandReady = !waiting && !sending;
	assign accept = CommandValid && CommandReady;

	BeatCounter #(.BeatsPerBlock(BeatsPerBlock)) i_beatCounter (
		.Clock(Clock), .arstN(arstN),
		.BeatStep(sending), .BeatClear(accept),
		.BeatIndex(), .LastBeat(lastBeat)
	);

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			waiting <= 1'b0;
			sending <= 1'b0;
			timer <= '0;
			lfsr <= 64'hACE1_2468_BDF1_3579;
		end else begin
			if (accept) begin
				waiting <= 1'b1;
				timer <= TimerWidth'(DummyLatency - 1);
			end else if (waiting) begin
				// First beat DummyLatency cycles after accept
				if (timer == '0) begin
					waiting <= 1'b0;
					sending <= 1'b1;
				end else begin
					timer <= timer - 1'b1;
				end
			end else if (sending && lastBeat) begin
				sending <= 1'b0;
			end
			// x^64 + x^63 + x^61 + x^60 + 1
			if (sending)
				lfsr <= {lfsr[62:0], lfsr[63] ^ lfsr[62] ^ lfsr[60] ^ lfsr[59]};
		end
	end

	assign ReadData = lfsr;
	assign ReadDataValid = sending;

endmodule

//--- src/OramTestWrap.sv
`timescale 1ns/1ps
// Tapeout test wrapper around the block engine
// Mode steering, traffic pattern generator and dummy DRAM responder
module OramTestWrap import OramTestPkg::*; #(
	parameter int BeatsPerBlock = 4,
	parameter int PatternBlocks = 8,
	parameter int DummyLatency = 3,
	localparam int IndexWidth = (BeatsPerBlock > 1) ? $clog2(BeatsPerBlock) : 1
) (
	input  logic                     Clock,
	input  logic                     arstN,
	// User command
	input  logic [CmdWidth-1:0]      Cmd,
	input  logic [AddrWidth-1:0]     PAddr,
	input  logic [BeatsPerBlock-1:0] WMask,
	input  logic                     CmdValid,
	output logic                     CmdReady,
	// User data
	input  logic [DataWidth-1:0]     DataIn,
	input  logic                     DataInValid,
	output logic                     DataInReady,
	output logic [DataWidth-1:0]     DataOut,
	output logic                     DataOutValid,
	input  logic                     DataOutReady,
	// DRAM
	output logic [DramAddrWidth-1:0] DramAddress,
	output logic [DramCmdWidth-1:0]  DramCommand,
	output logic                     DramCommandValid,
	input  logic                     DramCommandReady,
	input  logic [DataWidth-1:0]     DramReadData,
	input  logic                     DramReadDataValid,
	output logic [DataWidth-1:0]     DramWriteData,
	output logic [MaskWidth-1:0]     DramWriteMask,
	output logic                     DramWriteDataValid,
	input  logic                     DramWriteDataReady,
	// Test modes and status
	input  logic                     ModeTrafficGen,
	input  logic                     ModeDummyGen,
	output logic                     PatternDone,
	output logic [7:0]               PatternErrors
);

	// Engine user side
	logic [CmdWidth-1:0] engCmd;
	logic [AddrWidth-1:0] engPAddr;
	logic [BeatsPerBlock-1:0] engWMask;
	logic engCmdValid;
	logic engCmdReady;
	logic [DataWidth-1:0] engDataIn;
	logic engDataInValid;
	logic engDataInReady;
	logic engDataOutValid;
	logic engDataOutReady;
	// Engine DRAM side
	logic [DramCmdWidth-1:0] engDramCommand;
	logic engDramCommandValid;
	logic engDramCommandReady;
	logic [DataWidth-1:0] engDramReadData;
	logic engDramReadDataValid;
	logic engDramWriteDataValid;
	logic engDramWriteDataReady;
	// Engine internals
	logic beatStep;
	logic beatClear;
	logic lastBeat;
	logic [IndexWidth-1:0] beatIndex;
	logic bufWrite;
	logic bufFromDram;
	logic loadMask;
	logic [DataWidth-1:0] beatData;
	logic [MaskWidth-1:0] beatMask;
	// Traffic generator
	logic [CmdWidth-1:0] tgCmd;
	logic [AddrWidth-1:0] tgPAddr;
	logic tgCmdValid;
	logic tgCmdReady;
	logic [DataWidth-1:0] tgDataIn;
	logic tgDataInValid;
	logic tgDataInReady;
	logic tgDataOutValid;
	logic tgDataOutReady;
	// Dummy responder
	logic dgCmdValid;
	logic dgCmdReady;
	logic [DataWidth-1:0] dgReadData;
	logic dgReadDataValid;
	// Who owns the engine user port
	logic pinSide;
	logic tgSide;

	// ----------------------------------------------------------
	// User port steering, dummy mode blocks both sides
	// ----------------------------------------------------------
	assign pinSide = !ModeTrafficGen && !ModeDummyGen;
	assign tgSide = ModeTrafficGen && !ModeDummyGen;

	assign engCmd = ModeTrafficGen ? tgCmd : Cmd;
	assign engPAddr = ModeTrafficGen ? tgPAddr : PAddr;
	// Generator always writes whole blocks
	assign engWMask = ModeTrafficGen ? {BeatsPerBlock{1'b1}} : WMask;
	assign engDataIn = ModeTrafficGen ? tgDataIn : DataIn;

	assign engCmdValid = (ModeTrafficGen ? tgCmdValid : CmdValid) && !ModeDummyGen;
	assign tgCmdReady = tgSide && engCmdReady;
	assign CmdReady = pinSide && engCmdReady;

	assign engDataInValid = (ModeTrafficGen ? tgDataInValid : DataInValid) && !ModeDummyGen;
	assign tgDataInReady = tgSide && engDataInReady;
	assign DataInReady = pinSide && engDataInReady;

	assign DataOut = beatData;
	assign tgDataOutValid = tgSide && engDataOutValid;
	assign DataOutValid = pinSide && engDataOutValid;
	assign engDataOutReady = (ModeTrafficGen ? tgDataOutReady : DataOutReady) && !ModeDummyGen;

	// ----------------------------------------------------------
	// DRAM port steering, dummy mode keeps the pins quiet
	// ----------------------------------------------------------
	assign DramCommand = engDramCommand;
	assign DramCommandValid = engDramCommandValid && !ModeDummyGen;
	assign dgCmdValid = ModeDummyGen && engDramCommandValid && (engDramCommand == DramCmdRead);
	assign engDramCommandReady = ModeDummyGen ? dgCmdReady : DramCommandReady;

	assign engDramReadData = ModeDummyGen ? dgReadData : DramReadData;
	assign engDramReadDataValid = ModeDummyGen ? dgReadDataValid : DramReadDataValid;

	assign DramWriteData = beatData;
	assign DramWriteMask = beatMask;
	assign DramWriteDataValid = engDramWriteDataValid && !ModeDummyGen;
	// Writes sink silently in dummy mode
	assign engDramWriteDataReady = ModeDummyGen || DramWriteDataReady;

	// Mask latched on command acceptance
	assign loadMask = engCmdValid && engCmdReady;

	// ----------------------------------------------------------
	// Block engine
	// ----------------------------------------------------------
	AccessFsm #(.BeatsPerBlock(BeatsPerBlock)) i_accessFsm (
		.Clock(Clock), .arstN(arstN),
		.Cmd(engCmd), .PAddr(engPAddr),
		.CmdValid(engCmdValid), .CmdReady(engCmdReady),
		.DataInValid(engDataInValid), .DataInReady(engDataInReady),
		.DataOutValid(engDataOutValid), .DataOutReady(engDataOutReady),
		.DramAddress(DramAddress), .DramCommand(engDramCommand),
		.DramCommandValid(engDramCommandValid), .DramCommandReady(engDramCommandReady),
		.DramReadDataValid(engDramReadDataValid),
		.DramWriteDataValid(engDramWriteDataValid), .DramWriteDataReady(engDramWriteDataReady),
		.DummyMode(ModeDummyGen), .LastBeat(lastBeat),
		.BeatStep(beatStep), .BeatClear(beatClear),
		.BufWrite(bufWrite), .BufFromDram(bufFromDram)
	);

	BeatCounter #(.BeatsPerBlock(BeatsPerBlock)) i_beatCounter (
		.Clock(Clock), .arstN(arstN),
		.BeatStep(beatStep), .BeatClear(beatClear),
		.BeatIndex(beatIndex), .LastBeat(lastBeat)
	);

	BlockBuffer #(.BeatsPerBlock(BeatsPerBlock)) i_blockBuffer (
		.Clock(Clock), .arstN(arstN),
		.BufWrite(bufWrite), .BufFromDram(bufFromDram), .BeatIndex(beatIndex),
		.WMask(engWMask), .LoadMask(loadMask),
		.DataIn(engDataIn), .DramReadData(engDramReadData),
		.BeatData(beatData), .BeatMask(beatMask)
	);

	// ----------------------------------------------------------
	// Self-test blocks
	// ----------------------------------------------------------
	TrafficPatternGen #(
		.BeatsPerBlock(BeatsPerBlock),
		.PatternBlocks(PatternBlocks)
	) i_trafficPatternGen (
		.Clock(Clock), .arstN(arstN), .Enable(ModeTrafficGen),
		.Cmd(tgCmd), .PAddr(tgPAddr), .CmdValid(tgCmdValid), .CmdReady(tgCmdReady),
		.DataIn(tgDataIn), .DataInValid(tgDataInValid), .DataInReady(tgDataInReady),
		.DataOut(beatData), .DataOutValid(tgDataOutValid), .DataOutReady(tgDataOutReady),
		.PatternDone(PatternDone), .PatternErrors(PatternErrors)
	);

	DummyReadResponder #(
		.BeatsPerBlock(BeatsPerBlock),
		.DummyLatency(DummyLatency)
	) i_dummyReadResponder (
		.Clock(Clock), .arstN(arstN),
		.CommandValid(dgCmdValid), .CommandReady(dgCmdReady),
		.ReadData(dgReadData), .ReadDataValid(dgReadDataValid)
	);

endmodule

//--- test/ClockGen.sv
`timescale 1ns/1ps
// Testbench clock and reset source
module ClockGen #(
	parameter real HalfPeriod = 5.0,
	parameter int ResetCycles = 10
) (
	output logic Clock,
	output logic arstN
);

	initial begin
		Clock = 1'b0;
		forever #(HalfPeriod) Clock = !Clock;
	end

	// Reset held low for the first cycles, released on a falling edge
	initial begin
		arstN = 1'b0;
		repeat (ResetCycles) @(posedge Clock);
		@(negedge Clock);
		arstN = 1'b1;
	end

endmodule

//--- test/OramTestWrap_asserts.sv
`timescale 1ns/1ps
// Mode isolation and output stability checks, bound into the wrapper
module OramTestWrap_asserts (
	input logic        Clock,
	input logic        arstN,
	input logic        ModeTrafficGen,
	input logic        ModeDummyGen,
	input logic        CmdReady,
	input logic        DataInReady,
	input logic        DataOutValid,
	input logic        DataOutReady,
	input logic [63:0] DataOut,
	input logic        DramCommandValid,
	input logic        DramWriteDataValid
);

	// Power mode keeps the DRAM pins quiet
	dramQuiet: assert property (@(posedge Clock) disable iff (!arstN)
		ModeDummyGen |-> !DramCommandValid && !DramWriteDataValid)
		else $error("DRAM valid raised in dummy mode");

	// Either test mode cuts the user pins off
	userQuiet: assert property (@(posedge Clock) disable iff (!arstN)
		(ModeTrafficGen || ModeDummyGen) |-> !CmdReady && !DataInReady && !DataOutValid)
		else $error("User handshake active in a test mode");

	// Stalled read data must hold
	outStable: assert property (@(posedge Clock) disable iff (!arstN)
		DataOutValid && !DataOutReady |=> $stable(DataOut))
		else $error("DataOut changed while stalled");

endmodule

bind OramTestWrap OramTestWrap_asserts i_asserts (
	.Clock(Clock), .arstN(arstN),
	.ModeTrafficGen(ModeTrafficGen), .ModeDummyGen(ModeDummyGen),
	.CmdReady(CmdReady), .DataInReady(DataInReady),
	.DataOutValid(DataOutValid), .DataOutReady(DataOutReady), .DataOut(DataOut),
	.DramCommandValid(DramCommandValid), .DramWriteDataValid(DramWriteDataValid)
);

//--- test/OramTestWrapTb.sv
`timescale 1ns/1ps
// Directed testbench for the ORAM test wrapper
// Holds a DRAM model, the test tasks, a watchdog and the summary
module OramTestWrapTb import OramTestPkg::*;;

	localparam int Bpb = 4;
	localparam int Accesses = 52;
	localparam int LimitCycles = 50 * Accesses + 2000;

	logic Clock, arstN;
	logic [CmdWidth-1:0] Cmd;
	logic [AddrWidth-1:0] PAddr;
	logic [Bpb-1:0] WMask;
	logic CmdValid, CmdReady, DataInValid, DataInReady, DataOutValid, DataOutReady;
	logic [DataWidth-1:0] DataIn, DataOut, DramReadData, DramWriteData;
	logic [DramAddrWidth-1:0] DramAddress;
	logic [DramCmdWidth-1:0] DramCommand;
	logic DramCommandValid, DramCommandReady, DramReadDataValid;
	logic [MaskWidth-1:0] DramWriteMask;
	logic DramWriteDataValid, DramWriteDataReady;
	logic ModeTrafficGen, ModeDummyGen, PatternDone;
	logic [7:0] PatternErrors;

	int mismatches = 0;
	int failures = 0;
	// DRAM model state
	logic [DataWidth-1:0] dramMem [int];
	logic [DataWidth-1:0] expMem [int];
	int wrBase, wrBeat, rdBase, rdBeat, rdLeft, rdWait;
	bit stallOn = 0;
	bit corruptArm = 0;

	ClockGen i_clockGen (.Clock(Clock), .arstN(arstN));

	OramTestWrap #(.BeatsPerBlock(Bpb), .PatternBlocks(8), .DummyLatency(3)) i_dut (.*);

	// ------------------------------------------------------------
	// DRAM model sampling transfers at the rising edge
	// ------------------------------------------------------------
	always @(posedge Clock) begin
		if (DramCommandValid && DramCommandReady) begin
			if (DramCommand == DramCmdWrite) begin
				wrBase = int'(DramAddress);
				wrBeat = 0;
			end else begin
				rdBase = int'(DramAddress);
				rdBeat = 0;
				rdLeft = Bpb;
				rdWait = 2;
			end
		end
		if (DramWriteDataValid && DramWriteDataReady) begin
			// All-ones mask drops the beat
			if (DramWriteMask == '0)
				dramMem[wrBase + wrBeat] = DramWriteData;
			wrBeat++;
		end
	end

	// Read beats and ready stalls change on the falling edge
	always @(negedge Clock) begin
		DramReadDataValid = 1'b0;
		if (rdLeft > 0) begin
			if (rdWait > 0)
				rdWait--;
			if (rdWait == 0) begin
				DramReadData = dramMem.exists(rdBase + rdBeat) ? dramMem[rdBase + rdBeat] : '0;
				if (corruptArm) begin
					DramReadData = DramReadData ^ 64'h1;
					corruptArm = 0;
				end
				DramReadDataValid = 1'b1;
				rdBeat++;
				rdLeft--;
			end
		end
		DramCommandReady = !stallOn || ($urandom % 4 != 0);
		DramWriteDataReady = !stallOn || ($urandom % 4 != 0);
		DataOutReady = !stallOn || ($urandom % 3 != 0);
	end

	task automatic checkValue(string name, logic [63:0] got, logic [63:0] want);
		assert (got === want)
		else begin
			$display("MISMATCH %s got %h expected %h", name, got, want);
			mismatches++;
		end
	endtask

	task automatic sendCmd(logic [CmdWidth-1:0] code, int addr, logic [Bpb-1:0] mask);
		@(negedge Clock);
		Cmd = code;
		PAddr = AddrWidth'(addr);
		WMask = mask;
		CmdValid = 1'b1;
		do @(posedge Clock); while (!CmdReady);
		@(negedge Clock);
		CmdValid = 1'b0;
	endtask

	// Block write with expected memory following the mask
	task automatic writeBlock(int addr, logic [Bpb-1:0] mask);
		logic [DataWidth-1:0] word;
		sendCmd(CmdWrite, addr, mask);
		for (int j = 0; j < Bpb; j++) begin
			word = {$urandom, $urandom};
			DataIn = word;
			DataInValid = 1'b1;
			do @(posedge Clock); while (!DataInReady);
			@(negedge Clock);
			DataInValid = 1'b0;
			if (mask[j])
				expMem[addr * Bpb + j] = word;
		end
		do @(posedge Clock); while (!CmdReady);
	endtask

	task automatic readBlock(int addr);
		sendCmd(CmdRead, addr, '1);
		for (int j = 0; j < Bpb; j++) begin
			do @(posedge Clock); while (!(DataOutValid && DataOutReady));
			checkValue("DataOut", DataOut, expMem[addr * Bpb + j]);
		end
		do @(posedge Clock); while (!CmdReady);
	endtask

	task automatic resetAndBasic();
		int addr;
		@(posedge arstN);
		@(posedge Clock);
		checkValue("CmdReady", 64'(CmdReady), 64'h1);
		checkValue("DataInReady", 64'(DataInReady), 64'h0);
		checkValue("DataOutValid", 64'(DataOutValid), 64'h0);
		checkValue("DramCommandValid", 64'(DramCommandValid), 64'h0);
		checkValue("DramWriteDataValid", 64'(DramWriteDataValid), 64'h0);
		addr = $urandom % 1024;
		writeBlock(addr, '1);
		readBlock(addr);
	endtask

	task automatic partialMask();
		int addr;
		addr = 2000;
		writeBlock(addr, '1);
		writeBlock(addr, 4'b0101);
		for (int j = 0; j < Bpb; j++)
			checkValue("dramMem", dramMem[addr * Bpb + j], expMem[addr * Bpb + j]);
		readBlock(addr);
	endtask

	task automatic stalledTraffic();
		stallOn = 1;
		for (int i = 0; i < 6; i++)
			writeBlock(100 + 7 * i, '1);
		for (int i = 5; i >= 0; i--)
			readBlock(100 + 7 * i);
		stallOn = 0;
	endtask

	task automatic patternRun(int wantErrors);
		@(negedge Clock);
		ModeTrafficGen = 1'b1;
		repeat (2) @(posedge Clock);
		do @(posedge Clock); while (!PatternDone);
		checkValue("PatternErrors", 64'(PatternErrors), 64'(wantErrors));
		@(negedge Clock);
		ModeTrafficGen = 1'b0;
	endtask

	task automatic trafficMode();
		logic [15:0] v;
		patternRun(0);
		for (int b = 0; b < 8; b++) begin
			for (int j = 0; j < Bpb; j++) begin
				v = 16'(b * 256 + j);
				checkValue("dramMem", dramMem[b * Bpb + j], {4{v}});
			end
		end
		corruptArm = 1;
		patternRun(1);
	endtask

	task automatic dummyMode();
		int addr;
		@(negedge Clock);
		ModeDummyGen = 1'b1;
		repeat (200) begin
			@(posedge Clock);
			assert (!CmdReady && !DataInReady && !DataOutValid &&
				!DramCommandValid && !DramWriteDataValid)
			else begin
				$display("Handshake pin active during dummy mode");
				failures++;
			end
		end
		// Leave only when the engine sits in Idle
		do @(negedge Clock); while (i_dut.i_accessFsm.state != 0);
		ModeDummyGen = 1'b0;
		addr = 555;
		writeBlock(addr, '1);
		readBlock(addr);
	endtask

	initial begin
		void'($urandom(44));
		Cmd = CmdRead;
		PAddr = '0;
		WMask = '1;
		CmdValid = 1'b0;
		DataIn = '0;
		DataInValid = 1'b0;
		DataOutReady = 1'b1;
		DramCommandReady = 1'b1;
		DramReadData = '0;
		DramReadDataValid = 1'b0;
		DramWriteDataReady = 1'b1;
		ModeTrafficGen = 1'b0;
		ModeDummyGen = 1'b0;
		rdLeft = 0;
		rdWait = 0;
		resetAndBasic();
		partialMask();
		stalledTraffic();
		trafficMode();
		dummyMode();
		repeat (5) @(posedge Clock);
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// Watchdog sized from the access count
	initial begin
		repeat (LimitCycles) @(posedge Clock);
		$display("Timeout: run did not finish within %0d cycles", LimitCycles);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- verilog.f
src/OramTestPkg.sv
src/BeatCounter.sv
src/BlockBuffer.sv
src/AccessFsm.sv
src/TrafficPatternGen.sv
src/DummyReadResponder.sv
src/OramTestWrap.sv
test/ClockGen.sv
test/OramTestWrap_asserts.sv
test/OramTestWrapTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only on the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module OramTestWrapTb -f verilog.f -o simv
if [ $? -ne 0 ]; then
	echo "Build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
exit 1
